// ==== flist.f ====
+incdir+rtl
rtl/axi_source_pkg.sv
rtl/burst_issuer.sv
rtl/beat_repacker.sv
rtl/word_fifo.sv
rtl/axi_source.sv
verif/axi_mem_model.sv
verif/tb_axi_source.sv

// ==== Bender.yml ====
package:
  name: axi_source

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/axi_source_pkg.sv
      - rtl/burst_issuer.sv
      - rtl/beat_repacker.sv
      - rtl/word_fifo.sv
      - rtl/axi_source.sv
  - target: test
    files:
      - verif/axi_mem_model.sv
      - verif/tb_axi_source.sv

// ==== verif/tb_axi_source.sv ====
module tb_axi_source;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned WIDTH      = 24;
   localparam int unsigned SIZE       = 128;
   localparam int unsigned NBATCH     = 3;
   localparam int unsigned WORD_BYTES = WIDTH / 8;
   // three streams, generously under 100 cycles per word, plus setup.
   localparam int unsigned TIMEOUT_CYCLES = 100 * 3 * SIZE + 1600;

   logic                      clk_i;
   logic                      rst_ni;
   logic                      en_i;
   logic                      aval_i;
   axi_source_pkg::addr_t     addr_i;
   logic                      rdy_i = 1'b0;
   logic                      valid_o;
   logic [WIDTH-1:0]          data_o;
   logic                      m_axi_arready_i;
   logic                      m_axi_rlast_i;
   logic                      m_axi_rvalid_i;
   axi_source_pkg::axi_resp_e m_axi_rresp_i = axi_source_pkg::RESP_OKAY;
   axi_source_pkg::beat_t     m_axi_rdata_i;
   logic [5:0]                m_axi_rid_i = '0;
   logic                      m_axi_arvalid_o;
   logic                      m_axi_rready_o;
   logic [1:0]                m_axi_arburst_o;
   logic [1:0]                m_axi_arlock_o;
   logic [2:0]                m_axi_arsize_o;
   logic [2:0]                m_axi_arprot_o;
   axi_source_pkg::addr_t     m_axi_araddr_o;
   logic [3:0]                m_axi_arcache_o;
   logic [3:0]                m_axi_arlen_o;
   logic [3:0]                m_axi_arqos_o;
   logic [5:0]                m_axi_arid_o;

   logic                      mem_idle;
   logic                      consume = 1'b0;
   logic                      en_low_phase;
   logic                      started;
   axi_source_pkg::addr_t     base_q;
   int unsigned               idx_q;
   int unsigned               ar_cnt;
   int                        errors = 0;

   axi_source #(.WIDTH(WIDTH), .SIZE(SIZE)) DUT (.*);

   axi_mem_model u_mem (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .arvalid_i (m_axi_arvalid_o),
      .araddr_i  (m_axi_araddr_o),
      .arready_o (m_axi_arready_i),
      .rvalid_o  (m_axi_rvalid_i),
      .rdata_o   (m_axi_rdata_i),
      .rlast_o   (m_axi_rlast_i),
      .rready_i  (m_axi_rready_o),
      .idle_o    (mem_idle)
   );

   // word k of a stream packs bytes base+3k and up, byte 0 lowest.
   function automatic logic [WIDTH-1:0] expected_word(axi_source_pkg::addr_t b, int unsigned k);
      logic [WIDTH-1:0] w;
      for (int j = 0; j < WORD_BYTES; j++) begin
         w[j*8 +: 8] = 8'(b + k * WORD_BYTES + j) ^ 8'h5A;
      end
      return w;
   endfunction

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // reference position, restarted by every start pulse.
   always @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         base_q  <= '0;
         idx_q   <= 0;
         ar_cnt  <= 0;
         started <= 1'b0;
      end else if (aval_i) begin
         base_q  <= addr_i;
         idx_q   <= 0;
         ar_cnt  <= 0;
         started <= 1'b1;
      end else begin
         if (valid_o && rdy_i) begin
            idx_q <= idx_q + 1;
         end
         if (m_axi_arvalid_o && m_axi_arready_i) begin
            ar_cnt <= ar_cnt + 1;
         end
      end
   end

   always @(negedge clk_i) begin
      rdy_i = consume && (($urandom % 4) != 0);
   end

   reset_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !started |-> !m_axi_arvalid_o && !m_axi_rready_o && !valid_o)
      else begin
         errors++;
         $display("[FAIL] reset_idle expected 000 actual %b%b%b", $sampled(m_axi_arvalid_o),
                  $sampled(m_axi_rready_o), $sampled(valid_o));
      end

   // address, len, size, burst, then lock, prot, cache, qos and id all zero.
   ar_request_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_axi_arvalid_o && m_axi_arready_i |-> ar_cnt < NBATCH && m_axi_arlen_o == 4'd15 &&
      m_axi_arsize_o == 3'd3 && m_axi_arburst_o == 2'b01 &&
      m_axi_arlock_o == '0 && m_axi_arprot_o == '0 && m_axi_arcache_o == '0 &&
      m_axi_arqos_o == '0 && m_axi_arid_o == '0 &&
      m_axi_araddr_o == base_q + axi_source_pkg::addr_t'(ar_cnt * 128))
      else begin
         errors++;
         $display("[FAIL] ar_request #%0d expected %h/f/3/1/0 actual %h/%h/%0d/%0d/%h",
                  $sampled(ar_cnt), $sampled(base_q) + $sampled(ar_cnt) * 128,
                  $sampled(m_axi_araddr_o), $sampled(m_axi_arlen_o),
                  $sampled(m_axi_arsize_o), $sampled(m_axi_arburst_o),
                  {$sampled(m_axi_arlock_o), $sampled(m_axi_arprot_o),
                   $sampled(m_axi_arcache_o), $sampled(m_axi_arqos_o),
                   $sampled(m_axi_arid_o)});
      end

   ar_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_axi_arvalid_o && !m_axi_arready_i && !aval_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o))
      else begin
         errors++;
         $display("AR request changed or dropped before it was accepted");
      end

   word_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_o && rdy_i |-> idx_q < SIZE && data_o == expected_word(base_q, idx_q))
      else begin
         errors++;
         $display("[FAIL] word %0d expected %h actual %h", $sampled(idx_q),
                  expected_word($sampled(base_q), $sampled(idx_q)), $sampled(data_o));
      end

   restart_clear_a: assert property (@(posedge clk_i) disable iff (!rst_ni) aval_i |=> !valid_o)
      else begin
         errors++;
         $display("valid_o still high one cycle after a start pulse");
      end

   en_low_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      en_low_phase |-> !m_axi_arvalid_o && !valid_o)
      else begin
         errors++;
         $display("burst request or data seen after a start with en_i low");
      end

   task automatic start_stream(input axi_source_pkg::addr_t a, input logic enable);
      @(negedge clk_i);
      aval_i = 1'b1;
      addr_i = a;
      en_i   = enable;
      @(negedge clk_i);
      aval_i = 1'b0;
   endtask

   task automatic check_burst_total();
      burst_total_a: assert (ar_cnt == NBATCH)
         else begin
            errors++;
            $display("[FAIL] burst_total expected %0d actual %0d", NBATCH, ar_cnt);
         end
   endtask

   initial begin
      void'($urandom(57));
      rst_ni       = 1'b0;
      en_i         = 1'b0;
      aval_i       = 1'b0;
      addr_i       = '0;
      en_low_phase = 1'b0;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      repeat (20) @(negedge clk_i);

      // start with fetching disabled.
      en_low_phase = 1'b1;
      start_stream(32'h0000_1000, 1'b0);
      repeat (60) @(negedge clk_i);
      en_low_phase = 1'b0;

      // full stream, consumer and memory both stall at random.
      consume = 1'b1;
      start_stream(32'h0001_0040, 1'b1);
      wait (idx_q == SIZE);
      @(negedge clk_i);
      check_burst_total();

      // fill the FIFO with the consumer stalled, drain part of it.
      consume = 1'b0;
      start_stream(32'h0002_0108, 1'b1);
      wait (ar_cnt == NBATCH);
      repeat (2) @(negedge clk_i);
      wait (mem_idle);
      check_burst_total();
      consume = 1'b1;
      wait (idx_q >= 40);
      @(negedge clk_i);
      consume = 1'b0;

      // restart mid-stream from a new base.
      start_stream(32'h0003_0011, 1'b1);
      consume = 1'b1;
      wait (idx_q == SIZE);
      @(negedge clk_i);
      check_burst_total();
      repeat (20) @(negedge clk_i);

      $display("checks failed: %0d", errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk_i);
      $display("timeout after %0d cycles, the streams did not complete", TIMEOUT_CYCLES);
      $display("checks failed: %0d", errors);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== verif/axi_mem_model.sv ====
module axi_mem_model (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  arvalid_i,
   input  axi_source_pkg::addr_t araddr_i,
   output logic                  arready_o,
   output logic                  rvalid_o,
   output axi_source_pkg::beat_t rdata_o,
   output logic                  rlast_o,
   input  logic                  rready_i,
   output logic                  idle_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned BEATS      = 16;
   localparam int unsigned BEAT_BYTES = 8;

   axi_source_pkg::addr_t ar_q[$];
   int unsigned           beat_n;
   logic                  r_hs;

   // byte at address a reads as a XOR 0x5A.
   function automatic axi_source_pkg::beat_t beat_data(axi_source_pkg::addr_t a);
      axi_source_pkg::beat_t d;
      for (int j = 0; j < BEAT_BYTES; j++) begin
         d[j*8 +: 8] = 8'(a + j) ^ 8'h5A;
      end
      return d;
   endfunction

   // requests and beats accepted at the rising edge.
   always @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         ar_q.delete();
         beat_n = 0;
         r_hs   = 1'b0;
      end else begin
         r_hs = rvalid_o && rready_i;
         if (arvalid_i && arready_o) begin
            ar_q.push_back(araddr_i);
         end
         if (r_hs) begin
            if (beat_n == BEATS - 1) begin
               beat_n = 0;
               void'(ar_q.pop_front());
            end else begin
               beat_n++;
            end
         end
      end
   end

   // outputs move on the falling edge, with random gaps.
   always @(negedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         arready_o = 1'b0;
         rvalid_o  = 1'b0;
         rdata_o   = '0;
         rlast_o   = 1'b0;
         idle_o    = 1'b1;
      end else begin
         arready_o = ($urandom % 4) != 0;
         if (!rvalid_o || r_hs) begin
            rvalid_o = (ar_q.size() > 0) && (($urandom % 4) != 0);
            if (rvalid_o) begin
               rdata_o = beat_data(ar_q[0] + beat_n * BEAT_BYTES);
               rlast_o = (beat_n == BEATS - 1);
            end
         end
         idle_o = (ar_q.size() == 0) && !rvalid_o;
      end
   end

endmodule

// ==== rtl/axi_source.sv ====
`include "axi_source_settings.svh"

module axi_source #(
   parameter int unsigned WIDTH = 24,
   parameter int unsigned SIZE  = 128
) (
   input  logic                      clk_i,
   input  logic                      rst_ni,

   input  logic                      en_i,
   input  logic                      aval_i,
   input  axi_source_pkg::addr_t     addr_i,

   input  logic                      rdy_i,
   output logic                      valid_o,
   output logic [WIDTH-1:0]          data_o,

   input  logic                      m_axi_arready_i,
   input  logic                      m_axi_rlast_i,
   input  logic                      m_axi_rvalid_i,
   input  axi_source_pkg::axi_resp_e m_axi_rresp_i,
   input  axi_source_pkg::beat_t     m_axi_rdata_i,
   input  logic [5:0]                m_axi_rid_i,
   output logic                      m_axi_arvalid_o,
   output logic                      m_axi_rready_o,
   output logic [1:0]                m_axi_arburst_o,
   output logic [1:0]                m_axi_arlock_o,
   output logic [2:0]                m_axi_arsize_o,
   output logic [2:0]                m_axi_arprot_o,
   output axi_source_pkg::addr_t     m_axi_araddr_o,
   output logic [3:0]                m_axi_arcache_o,
   output logic [3:0]                m_axi_arlen_o,
   output logic [3:0]                m_axi_arqos_o,
   output logic [5:0]                m_axi_arid_o
);

   localparam int unsigned BURST_BITS = axi_source_pkg::BURST_BYTES * 8;
   localparam int unsigned NBATCH     = (WIDTH * SIZE + BURST_BITS - 1) / BURST_BITS;
   localparam int unsigned OUT_BYTES  = WIDTH / 8;

   logic             rp_valid;
   logic [WIDTH-1:0] rp_data;
   logic             fifo_rdy;

   // address side.
   burst_issuer #(
      .NBATCH (NBATCH)
   ) i_issuer (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .start_i      (aval_i),
      .en_i         (en_i),
      .start_addr_i (addr_i),
      .arready_i    (m_axi_arready_i),
      .arvalid_o    (m_axi_arvalid_o),
      .araddr_o     (m_axi_araddr_o)
   );

   // data side, beats in order, so rlast, rresp and rid go unread.
   beat_repacker #(
      .OUT_BYTES (OUT_BYTES)
   ) i_repacker (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .srst_i      (aval_i),
      .rvalid_i    (m_axi_rvalid_i),
      .rdata_i     (m_axi_rdata_i),
      .rready_o    (m_axi_rready_o),
      .out_valid_o (rp_valid),
      .out_data_o  (rp_data),
      .out_ready_i (fifo_rdy)
   );

   word_fifo #(
      .WIDTH (WIDTH)
   ) i_fifo (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .srst_i      (aval_i),
      .in_valid_i  (rp_valid),
      .in_data_i   (rp_data),
      .in_ready_o  (fifo_rdy),
      .pop_i       (rdy_i),
      .out_valid_o (valid_o),
      .out_data_o  (data_o)
   );

   // fixed incrementing bursts of full-width beats.
   assign m_axi_arburst_o = axi_source_pkg::BURST_INCR;
   assign m_axi_arlock_o  = '0;
   assign m_axi_arsize_o  = 3'($clog2(`AXI_BEAT_BYTES));
   assign m_axi_arprot_o  = '0;
   assign m_axi_arcache_o = '0;
   assign m_axi_arlen_o   = 4'(`AXI_BURST_BEATS - 1);
   assign m_axi_arqos_o   = '0;
   assign m_axi_arid_o    = '0;

endmodule

// ==== rtl/word_fifo.sv ====
`include "axi_source_settings.svh"

module word_fifo #(
   parameter int unsigned WIDTH = 24
) (
   input  logic             clk_i,
   input  logic             rst_ni,
   input  logic             srst_i,

   input  logic             in_valid_i,
   input  logic [WIDTH-1:0] in_data_i,
   output logic             in_ready_o,

   input  logic             pop_i,
   output logic             out_valid_o,
   output logic [WIDTH-1:0] out_data_o
);

   localparam int unsigned PTR_W = `FIFO_DEPTH_LOG2;
   localparam int unsigned DEPTH = 1 << PTR_W;

   localparam logic [PTR_W:0] FULL_CNT = {1'b1, {PTR_W{1'b0}}};

   logic [WIDTH-1:0] mem_q [DEPTH];
   logic [PTR_W-1:0] wptr_q;
   logic [PTR_W-1:0] rptr_q;
   logic [PTR_W:0]   fill_q;
   logic             push;
   logic             pop;

   assign in_ready_o  = (fill_q != FULL_CNT);
   assign out_valid_o = (fill_q != '0);
   assign push        = in_valid_i && in_ready_o;
   assign pop         = pop_i && out_valid_o;

   // head word read straight from storage.
   assign out_data_o = mem_q[rptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wptr_q] <= in_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wptr_q <= '0;
         rptr_q <= '0;
         fill_q <= '0;
      end else if (srst_i) begin
         wptr_q <= '0;
         rptr_q <= '0;
         fill_q <= '0;
      end else begin
         if (push) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (pop) begin
            rptr_q <= rptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   fill_q <= fill_q + 1'b1;
            2'b01:   fill_q <= fill_q - 1'b1;
            default: fill_q <= fill_q;
         endcase
      end
   end

   // fill count agrees with the pointers and never passes full.
   fill_track_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fill_q <= FULL_CNT && fill_q[PTR_W-1:0] == PTR_W'(wptr_q - rptr_q));

endmodule

// ==== rtl/beat_repacker.sv ====
`include "axi_source_settings.svh"

module beat_repacker #(
   parameter int unsigned OUT_BYTES = 3
) (
   input  logic                   clk_i,
   input  logic                   rst_ni,
   input  logic                   srst_i,

   input  logic                   rvalid_i,
   input  axi_source_pkg::beat_t  rdata_i,
   output logic                   rready_o,

   output logic                   out_valid_o,
   output logic [OUT_BYTES*8-1:0] out_data_o,
   input  logic                   out_ready_i
);

   localparam int unsigned BUFF_BYTES = `REPACK_BUFF_BYTES;
   localparam int unsigned BEAT_BYTES = `AXI_BEAT_BYTES;
   localparam int unsigned CNT_W      = $clog2(BUFF_BYTES + 1);

   localparam logic [CNT_W-1:0] OUT_CNT  = CNT_W'(OUT_BYTES);
   localparam logic [CNT_W-1:0] BEAT_CNT = CNT_W'(BEAT_BYTES);
   localparam logic [CNT_W-1:0] BUFF_CNT = CNT_W'(BUFF_BYTES);

   logic                    armed_q;
   logic                    hold_valid_q;
   axi_source_pkg::beat_t   hold_data_q;
   logic [BUFF_BYTES*8-1:0] buf_q;
   logic [BUFF_BYTES*8-1:0] buf_d;
   logic [CNT_W-1:0]        count_q;
   logic [CNT_W-1:0]        avail;
   logic                    take_word;
   logic                    append;
   logic                    beat_hs;

   assign out_valid_o = (count_q >= OUT_CNT);
   assign out_data_o  = buf_q[OUT_BYTES*8-1:0];
   assign take_word   = out_valid_o && out_ready_i;

   // bytes left once this cycle's word is gone.
   assign avail  = take_word ? (count_q - OUT_CNT) : count_q;
   assign append = hold_valid_q && (avail <= (BUFF_CNT - BEAT_CNT));

   // nothing is fetched before the first start.
   assign rready_o = armed_q && (!hold_valid_q || append);
   assign beat_hs  = rvalid_i && rready_o;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         armed_q <= 1'b0;
      end else if (srst_i) begin
         armed_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         hold_valid_q <= 1'b0;
      end else if (srst_i) begin
         hold_valid_q <= 1'b0;
      end else if (beat_hs) begin
         hold_valid_q <= 1'b1;
      end else if (append) begin
         hold_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (beat_hs) begin
         hold_data_q <= rdata_i;
      end
   end

   // drop the outgoing word, then place the beat above what remains.
   always_comb begin
      buf_d = take_word ? (buf_q >> (OUT_BYTES * 8)) : buf_q;
      if (append) begin
         for (int i = 0; i < BEAT_BYTES; i++) begin
            buf_d[(avail + i) * 8 +: 8] = hold_data_q[i * 8 +: 8];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      buf_q <= buf_d;
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         count_q <= '0;
      end else if (srst_i) begin
         count_q <= '0;
      end else begin
         count_q <= append ? (avail + BEAT_CNT) : avail;
      end
   end

   count_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      count_q <= BUFF_CNT);

endmodule

// ==== rtl/burst_issuer.sv ====
module burst_issuer #(
   parameter int unsigned NBATCH = 3
) (
   input  logic                  clk_i,
   input  logic                  rst_ni,

   input  logic                  start_i,
   input  logic                  en_i,
   input  axi_source_pkg::addr_t start_addr_i,

   input  logic                  arready_i,
   output logic                  arvalid_o,
   output axi_source_pkg::addr_t araddr_o
);

   localparam axi_source_pkg::addr_t BURST_STEP =
      axi_source_pkg::addr_t'(axi_source_pkg::BURST_BYTES);
   localparam axi_source_pkg::addr_t LAST_OFFSET =
      axi_source_pkg::addr_t'((NBATCH - 1) * axi_source_pkg::BURST_BYTES);

   axi_source_pkg::addr_t cur_addr_q;
   axi_source_pkg::addr_t last_addr_q;
   logic                  arvalid_q;
   logic                  ar_hs;
   logic                  at_last;

   assign ar_hs   = arvalid_q && arready_i;
   assign at_last = (cur_addr_q == last_addr_q);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cur_addr_q  <= '0;
         last_addr_q <= '0;
      end else if (start_i) begin
         cur_addr_q  <= start_addr_i;
         last_addr_q <= start_addr_i + LAST_OFFSET;
      end else if (ar_hs) begin
         cur_addr_q <= cur_addr_q + BURST_STEP;
      end
   end

   // en_i is only looked at on start and on each accepted burst.
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         arvalid_q <= 1'b0;
      end else if (start_i) begin
         arvalid_q <= en_i;
      end else if (ar_hs) begin
         arvalid_q <= !at_last && en_i;
      end
   end

   assign arvalid_o = arvalid_q;
   assign araddr_o  = cur_addr_q;

   // request must hold until accepted, a restart excepted.
   ar_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      arvalid_o && !arready_i && !start_i |=> arvalid_o && $stable(araddr_o));

endmodule

// ==== rtl/axi_source_pkg.sv ====
`include "axi_source_settings.svh"

package axi_source_pkg;

   typedef logic [`AXI_ADDR_W-1:0] addr_t;

   typedef logic [`AXI_DATA_W-1:0] beat_t;

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   // address step between consecutive bursts.
   localparam int unsigned BURST_BYTES = `AXI_BURST_BEATS * `AXI_BEAT_BYTES;

endpackage

// ==== rtl/axi_source_settings.svh ====
`ifndef AXI_SOURCE_SETTINGS_SVH
`define AXI_SOURCE_SETTINGS_SVH

// read data bus width in bits.
`define AXI_DATA_W 64

// byte address width.
`define AXI_ADDR_W 32

// beats in every AR burst, arlen is this minus one.
`define AXI_BURST_BEATS 16

// bytes carried by one beat.
`define AXI_BEAT_BYTES 8

// repacker byte buffer capacity.
`define REPACK_BUFF_BYTES 32

// word fifo holds 2**n entries.
`define FIFO_DEPTH_LOG2 7

`endif
